//--- translation_unit.f
rtl/tu_pkg.sv
rtl/tlb_table.sv
rtl/tlb_match.sv
rtl/addr_xlate.sv
rtl/tu_cp0_regs.sv
rtl/translation_unit.sv
sim/tb_clkgen.sv
sim/tb_translation_unit.sv

//--- run_sim.sh
#!/bin/sh
# builds the translation unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_translation_unit \
    -f translation_unit.f -Mdir obj_dir -o sim_tu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- sim/tb_translation_unit.sv
`timescale 1ns/1ps

module tb_translation_unit
    import tu_pkg::*;
();

    localparam int REG_OPS     = 40;
    localparam int RT_ITERS    = 24;
    localparam int PROBE_ITERS = 32;
    localparam int MAP_ITERS   = 200;
    localparam int UNMAP_ITERS = 100;
    localparam int CYCLE_LIMIT = 10 + REG_OPS * 2 + RT_ITERS * 20 + PROBE_ITERS * 4
                                 + MAP_ITERS * 2 + 20 + UNMAP_ITERS + 100;

    localparam int OP_TLBWI = 0;
    localparam int OP_TLBR  = 1;
    localparam int OP_TLBP  = 2;

    // global kseg entries with a valid even page and an invalid odd page
    localparam word_t KSEG_LO_EVEN = {6'd0, 20'h12345, 3'd3, 1'b0, 1'b1, 1'b1};
    localparam word_t KSEG_LO_ODD  = {6'd0, 20'h2468a, 3'd3, 1'b0, 1'b0, 1'b1};

    logic        clk;
    logic        resetn;
    logic        i_k0_uncached;
    logic        i_cp0_we;
    logic [1:0]  i_cp0_sel;
    word_t       i_cp0_wdata;
    logic        i_tlbwi;
    logic        i_tlbr;
    logic        i_tlbp;
    word_t       i_i_vaddr;
    word_t       o_i_paddr;
    logic        o_i_uncached;
    logic        o_i_refill;
    logic        o_i_invalid;
    word_t       i_d_vaddr;
    logic        i_d_store;
    word_t       o_d_paddr;
    logic        o_d_uncached;
    logic        o_d_refill;
    logic        o_d_invalid;
    logic        o_d_modified;
    word_t       o_entryhi;
    word_t       o_entrylo0;
    word_t       o_entrylo1;
    word_t       o_index;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          test_checks0;
    int          test_errors0;
    int          cycles;

    // reference copy of the table and CP0 registers
    tlb_entry_t  m_entries [TLB_ENTRIES];
    word_t       m_hi;
    word_t       m_lo0;
    word_t       m_lo1;
    tlb_idx_t    m_idx;
    logic        m_p;

    tb_clkgen u_clkgen (
        .clk    (clk),
        .resetn (resetn)
    );

    translation_unit dut0 (
        .clk           (clk),
        .resetn        (resetn),
        .i_k0_uncached (i_k0_uncached),
        .i_cp0_we      (i_cp0_we),
        .i_cp0_sel     (i_cp0_sel),
        .i_cp0_wdata   (i_cp0_wdata),
        .i_tlbwi       (i_tlbwi),
        .i_tlbr        (i_tlbr),
        .i_tlbp        (i_tlbp),
        .i_i_vaddr     (i_i_vaddr),
        .o_i_paddr     (o_i_paddr),
        .o_i_uncached  (o_i_uncached),
        .o_i_refill    (o_i_refill),
        .o_i_invalid   (o_i_invalid),
        .i_d_vaddr     (i_d_vaddr),
        .i_d_store     (i_d_store),
        .o_d_paddr     (o_d_paddr),
        .o_d_uncached  (o_d_uncached),
        .o_d_refill    (o_d_refill),
        .o_d_invalid   (o_d_invalid),
        .o_d_modified  (o_d_modified),
        .o_entryhi     (o_entryhi),
        .o_entrylo0    (o_entrylo0),
        .o_entrylo1    (o_entrylo1),
        .o_index       (o_index)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // none of these fall in kseg0/kseg1
    function automatic logic [18:0] pool_vpn2(input logic [1:0] sel);
        case (sel)
            2'd0:    return 19'h00010;
            2'd1:    return 19'h00123;
            2'd2:    return 19'h14567;
            default: return 19'h60002;
        endcase
    endfunction

    function automatic logic [7:0] pool_asid(input logic [1:0] sel);
        case (sel)
            2'd0:    return 8'h00;
            2'd1:    return 8'h01;
            2'd2:    return 8'h5a;
            default: return 8'hff;
        endcase
    endfunction

    // junk in the zero field should be dropped
    function automatic word_t rand_hi();
        word_t r;
        r = rand_bits(9);
        return {pool_vpn2(r[1:0]), r[6:2], pool_asid(r[8:7])};
    endfunction

    function automatic word_t mapped_addr();
        word_t r;
        r = rand_bits(15);
        return {pool_vpn2(r[1:0]), r[14:2]};
    endfunction

    // half of these land on the kseg entries planted in the table
    function automatic word_t unmapped_addr();
        word_t r;
        r = rand_bits(32);
        if (r[31]) begin
            return {(r[30] ? 19'h50000 : 19'h40000), r[12:0]};
        end
        return {2'b10, r[29:0]};
    endfunction

    function automatic void find_entry(input logic [18:0] vpn2, input logic [7:0] asid,
                                       output logic hit, output tlb_idx_t idx);
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && m_entries[i].vpn2 == vpn2 &&
                (m_entries[i].asid == asid || m_entries[i].g)) begin
                hit = 1'b1;
                idx = tlb_idx_t'(i);
            end
        end
    endfunction

    function automatic tlb_entry_t entry_from_regs();
        tlb_entry_t e;
        e.vpn2 = m_hi[31:13];
        e.asid = m_hi[7:0];
        e.g    = m_lo0[0] & m_lo1[0];
        e.pfn0 = m_lo0[25:6];
        e.c0   = m_lo0[5:3];
        e.d0   = m_lo0[2];
        e.v0   = m_lo0[1];
        e.pfn1 = m_lo1[25:6];
        e.c1   = m_lo1[5:3];
        e.d1   = m_lo1[2];
        e.v1   = m_lo1[1];
        return e;
    endfunction

    function automatic void model_xlate(input word_t va, input logic store, input logic k0u,
                                        output word_t pa, output logic unc,
                                        output logic refill, output logic inv,
                                        output logic modf);
        logic        hit;
        tlb_idx_t    idx;
        tlb_entry_t  e;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        refill = 1'b0;
        inv    = 1'b0;
        modf   = 1'b0;
        if (va[31:30] == 2'b10) begin
            pa  = {3'b000, va[28:0]};
            unc = va[29] | k0u;
        end else begin
            find_entry(va[31:13], m_hi[7:0], hit, idx);
            e = m_entries[idx];
            if (va[12]) begin
                {pfn, c, d, v} = {e.pfn1, e.c1, e.d1, e.v1};
            end else begin
                {pfn, c, d, v} = {e.pfn0, e.c0, e.d0, e.v0};
            end
            pa     = {pfn, va[11:0]};
            unc    = (c != CACHE_CACHEABLE);
            refill = !hit;
            inv    = hit && !v;
            modf   = hit && v && !d && store;
        end
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_regs();
        check_val("o_entryhi", o_entryhi, m_hi);
        check_val("o_entrylo0", o_entrylo0, m_lo0);
        check_val("o_entrylo1", o_entrylo1, m_lo1);
        check_val("o_index", o_index, {m_p, 27'd0, m_idx});
    endtask

    // address and uncached mean nothing on a refill
    task automatic check_xlate();
        word_t pa;
        logic  unc;
        logic  rf;
        logic  inv;
        logic  md;
        model_xlate(i_i_vaddr, 1'b0, i_k0_uncached, pa, unc, rf, inv, md);
        check_bit("o_i_refill", o_i_refill, rf);
        check_bit("o_i_invalid", o_i_invalid, inv);
        if (!rf) begin
            check_val("o_i_paddr", o_i_paddr, pa);
            check_bit("o_i_uncached", o_i_uncached, unc);
        end
        model_xlate(i_d_vaddr, i_d_store, i_k0_uncached, pa, unc, rf, inv, md);
        check_bit("o_d_refill", o_d_refill, rf);
        check_bit("o_d_invalid", o_d_invalid, inv);
        check_bit("o_d_modified", o_d_modified, md);
        if (!rf) begin
            check_val("o_d_paddr", o_d_paddr, pa);
            check_bit("o_d_uncached", o_d_uncached, unc);
        end
    endtask

    task automatic cp0_write(input logic [1:0] sel, input word_t data);
        @(posedge clk);
        i_cp0_we    <= 1'b1;
        i_cp0_sel   <= sel;
        i_cp0_wdata <= data;
        @(posedge clk);
        i_cp0_we    <= 1'b0;
        case (sel)
            CP0_SEL_INDEX:    m_idx = data[3:0];
            CP0_SEL_ENTRYHI:  m_hi  = {data[31:13], 5'd0, data[7:0]};
            CP0_SEL_ENTRYLO0: m_lo0 = {6'd0, data[25:0]};
            default:          m_lo1 = {6'd0, data[25:0]};
        endcase
        #1;
        check_regs();
    endtask

    task automatic tlb_op(input int op);
        tlb_entry_t e;
        logic       hit;
        tlb_idx_t   idx;
        @(posedge clk);
        case (op)
            OP_TLBWI: i_tlbwi <= 1'b1;
            OP_TLBR:  i_tlbr  <= 1'b1;
            default:  i_tlbp  <= 1'b1;
        endcase
        @(posedge clk);
        i_tlbwi <= 1'b0;
        i_tlbr  <= 1'b0;
        i_tlbp  <= 1'b0;
        if (op == OP_TLBWI) begin
            m_entries[m_idx] = entry_from_regs();
        end else if (op == OP_TLBR) begin
            e     = m_entries[m_idx];
            m_hi  = {e.vpn2, 5'd0, e.asid};
            m_lo0 = {6'd0, e.pfn0, e.c0, e.d0, e.v0, e.g};
            m_lo1 = {6'd0, e.pfn1, e.c1, e.d1, e.v1, e.g};
        end else begin
            find_entry(m_hi[31:13], m_hi[7:0], hit, idx);
            m_p   = !hit;
            m_idx = hit ? idx : 4'd0;
        end
        #1;
        check_regs();
    endtask

    task automatic write_entry(input tlb_idx_t idx, input word_t hi, input word_t lo0,
                               input word_t lo1);
        word_t w;
        w = rand_bits(32);
        w[3:0] = idx;
        cp0_write(CP0_SEL_INDEX, w);
        cp0_write(CP0_SEL_ENTRYHI, hi);
        cp0_write(CP0_SEL_ENTRYLO0, lo0);
        cp0_write(CP0_SEL_ENTRYLO1, lo1);
        tlb_op(OP_TLBWI);
    endtask

    task automatic apply_addrs(input word_t iva, input word_t dva, input logic store,
                               input logic k0u);
        @(posedge clk);
        i_i_vaddr     <= iva;
        i_d_vaddr     <= dva;
        i_d_store     <= store;
        i_k0_uncached <= k0u;
        #1;
        check_xlate();
    endtask

    task automatic start_test();
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks0,
                 errors - test_errors0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        word_t    r;
        word_t    w;
        tlb_idx_t widx;
        lfsr          = 32'h6391_31ef;
        checks        = 0;
        errors        = 0;
        cycles        = 0;
        i_k0_uncached = 1'b0;
        i_cp0_we      = 1'b0;
        i_cp0_sel     = 2'd0;
        i_cp0_wdata   = '0;
        i_tlbwi       = 1'b0;
        i_tlbr        = 1'b0;
        i_tlbp        = 1'b0;
        i_i_vaddr     = '0;
        i_d_vaddr     = '0;
        i_d_store     = 1'b0;
        m_hi          = '0;
        m_lo0         = '0;
        m_lo1         = '0;
        m_idx         = '0;
        m_p           = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m_entries[i] = '0;
        end
        wait (resetn === 1'b1);

        // an occasional probe flips p between writes
        start_test();
        for (int i = 0; i < REG_OPS; i++) begin
            r = rand_bits(5);
            if (r[2:0] == 3'd0) begin
                tlb_op(OP_TLBP);
            end else begin
                cp0_write(r[4:3], rand_bits(32));
            end
        end
        end_test("register access");

        start_test();
        for (int i = 0; i < RT_ITERS; i++) begin
            r = rand_bits(5);
            widx = r[3:0];
            write_entry(widx, rand_hi(), rand_bits(32), rand_bits(32));
            cp0_write(CP0_SEL_ENTRYHI, rand_bits(32));
            cp0_write(CP0_SEL_ENTRYLO0, rand_bits(32));
            cp0_write(CP0_SEL_ENTRYLO1, rand_bits(32));
            w = rand_bits(32);
            w[3:0] = r[4] ? widx : w[7:4];
            cp0_write(CP0_SEL_INDEX, w);
            tlb_op(OP_TLBR);
        end
        end_test("write/read round-trip");

        start_test();
        for (int i = 0; i < PROBE_ITERS; i++) begin
            cp0_write(CP0_SEL_ENTRYHI, rand_hi());
            tlb_op(OP_TLBP);
        end
        end_test("probe");

        // asid changes now and then between lookups
        start_test();
        for (int i = 0; i < MAP_ITERS; i++) begin
            r = rand_bits(6);
            if (r[3:0] == 4'd0) begin
                cp0_write(CP0_SEL_ENTRYHI, rand_hi());
            end else begin
                apply_addrs(mapped_addr(), mapped_addr(), r[4], r[5]);
            end
        end
        end_test("mapped translation");

        start_test();
        write_entry(4'd15, {19'h40000, 5'd0, 8'h00}, KSEG_LO_EVEN, KSEG_LO_ODD);
        write_entry(4'd14, {19'h50000, 5'd0, 8'h00}, KSEG_LO_EVEN, KSEG_LO_ODD);
        for (int i = 0; i < UNMAP_ITERS; i++) begin
            r = rand_bits(2);
            apply_addrs(unmapped_addr(), unmapped_addr(), r[0], r[1]);
        end
        end_test("unmapped translation");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic resetn
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held low for 5 rising edges
    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- rtl/translation_unit.sv
`timescale 1ns/1ps

module translation_unit
    import tu_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        i_k0_uncached,

    input  logic        i_cp0_we,
    input  logic [1:0]  i_cp0_sel,
    input  word_t       i_cp0_wdata,
    input  logic        i_tlbwi,
    input  logic        i_tlbr,
    input  logic        i_tlbp,

    input  word_t       i_i_vaddr,
    output word_t       o_i_paddr,
    output logic        o_i_uncached,
    output logic        o_i_refill,
    output logic        o_i_invalid,

    input  word_t       i_d_vaddr,
    input  logic        i_d_store,
    output word_t       o_d_paddr,
    output logic        o_d_uncached,
    output logic        o_d_refill,
    output logic        o_d_invalid,
    output logic        o_d_modified,

    output word_t       o_entryhi,
    output word_t       o_entrylo0,
    output word_t       o_entrylo1,
    output word_t       o_index
);

    cp0_word_u                      cp0_wdata;
    cp0_entryhi_t                   entryhi;

    logic                           tlb_we;
    tlb_idx_t                       tlb_idx;
    tlb_entry_t                     tlb_wdata;
    tlb_entry_t                     tlb_rdata;
    tlb_entry_t [TLB_ENTRIES-1:0]   entries;

    logic                           probe_hit;
    tlb_idx_t                       probe_idx;

    assign cp0_wdata.raw = i_cp0_wdata;
    assign o_entryhi     = entryhi;

    tu_cp0_regs u_cp0 (
        .clk          (clk),
        .resetn       (resetn),
        .i_cp0_we     (i_cp0_we),
        .i_cp0_sel    (i_cp0_sel),
        .i_cp0_wdata  (cp0_wdata),
        .i_tlbwi      (i_tlbwi),
        .i_tlbr       (i_tlbr),
        .i_tlbp       (i_tlbp),
        .i_rd_entry   (tlb_rdata),
        .i_probe_hit  (probe_hit),
        .i_probe_idx  (probe_idx),
        .o_tlb_we     (tlb_we),
        .o_tlb_idx    (tlb_idx),
        .o_tlb_wdata  (tlb_wdata),
        .o_entryhi    (entryhi),
        .o_entrylo0   (o_entrylo0),
        .o_entrylo1   (o_entrylo1),
        .o_index      (o_index)
    );

    tlb_table u_table (
        .clk        (clk),
        .resetn     (resetn),
        .i_we       (tlb_we),
        .i_waddr    (tlb_idx),
        .i_wdata    (tlb_wdata),
        .i_raddr    (tlb_idx),
        .o_rdata    (tlb_rdata),
        .o_entries  (entries)
    );

    // tlbp looks up EntryHi itself, page attributes are not needed
    tlb_match u_probe (
        .i_entries  (entries),
        .i_vaddr    (entryhi),
        .i_asid     (entryhi.asid),
        .o_hit      (probe_hit),
        .o_idx      (probe_idx),
        .o_pfn      (),
        .o_c        (),
        .o_d        (),
        .o_v        ()
    );

    // instruction fetch never stores
    addr_xlate u_ixlate (
        .i_vaddr        (i_i_vaddr),
        .i_store        (1'b0),
        .i_k0_uncached  (i_k0_uncached),
        .i_asid         (entryhi.asid),
        .i_entries      (entries),
        .o_paddr        (o_i_paddr),
        .o_uncached     (o_i_uncached),
        .o_refill       (o_i_refill),
        .o_invalid      (o_i_invalid),
        .o_modified     ()
    );

    addr_xlate u_dxlate (
        .i_vaddr        (i_d_vaddr),
        .i_store        (i_d_store),
        .i_k0_uncached  (i_k0_uncached),
        .i_asid         (entryhi.asid),
        .i_entries      (entries),
        .o_paddr        (o_d_paddr),
        .o_uncached     (o_d_uncached),
        .o_refill       (o_d_refill),
        .o_invalid      (o_d_invalid),
        .o_modified     (o_d_modified)
    );

endmodule

//--- rtl/tu_cp0_regs.sv
`timescale 1ns/1ps

module tu_cp0_regs
    import tu_pkg::*;
(
    input  logic          clk,
    input  logic          resetn,

    input  logic          i_cp0_we,
    input  logic [1:0]    i_cp0_sel,
    input  cp0_word_u     i_cp0_wdata,

    input  logic          i_tlbwi,
    input  logic          i_tlbr,
    input  logic          i_tlbp,

    input  tlb_entry_t    i_rd_entry,
    input  logic          i_probe_hit,
    input  tlb_idx_t      i_probe_idx,

    output logic          o_tlb_we,
    output tlb_idx_t      o_tlb_idx,
    output tlb_entry_t    o_tlb_wdata,

    output cp0_entryhi_t  o_entryhi,
    output cp0_entrylo_t  o_entrylo0,
    output cp0_entrylo_t  o_entrylo1,
    output cp0_index_t    o_index
);

    logic              idx_p;
    tlb_idx_t          idx_val;

    logic [18:0]       hi_vpn2;
    logic [7:0]        hi_asid;

    // [0] is EntryLo0, [1] is EntryLo1
    logic [1:0][19:0]  lo_pfn;
    logic [1:0][2:0]   lo_c;
    logic [1:0]        lo_d;
    logic [1:0]        lo_v;
    logic [1:0]        lo_g;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            idx_p   <= 1'b0;
            idx_val <= '0;
            hi_vpn2 <= '0;
            hi_asid <= '0;
            lo_pfn  <= '0;
            lo_c    <= '0;
            lo_d    <= '0;
            lo_v    <= '0;
            lo_g    <= '0;
        end else if (i_cp0_we) begin
            case (i_cp0_sel)
                // p is read-only to software
                CP0_SEL_INDEX: begin
                    idx_val <= i_cp0_wdata.index.index;
                end
                CP0_SEL_ENTRYHI: begin
                    hi_vpn2 <= i_cp0_wdata.entryhi.vpn2;
                    hi_asid <= i_cp0_wdata.entryhi.asid;
                end
                CP0_SEL_ENTRYLO0: begin
                    lo_pfn[0] <= i_cp0_wdata.entrylo.pfn;
                    lo_c[0]   <= i_cp0_wdata.entrylo.c;
                    lo_d[0]   <= i_cp0_wdata.entrylo.d;
                    lo_v[0]   <= i_cp0_wdata.entrylo.v;
                    lo_g[0]   <= i_cp0_wdata.entrylo.g;
                end
                CP0_SEL_ENTRYLO1: begin
                    lo_pfn[1] <= i_cp0_wdata.entrylo.pfn;
                    lo_c[1]   <= i_cp0_wdata.entrylo.c;
                    lo_d[1]   <= i_cp0_wdata.entrylo.d;
                    lo_v[1]   <= i_cp0_wdata.entrylo.v;
                    lo_g[1]   <= i_cp0_wdata.entrylo.g;
                end
            endcase
        end else if (i_tlbr) begin
            hi_vpn2 <= i_rd_entry.vpn2;
            hi_asid <= i_rd_entry.asid;
            lo_pfn  <= {i_rd_entry.pfn1, i_rd_entry.pfn0};
            lo_c    <= {i_rd_entry.c1, i_rd_entry.c0};
            lo_d    <= {i_rd_entry.d1, i_rd_entry.d0};
            lo_v    <= {i_rd_entry.v1, i_rd_entry.v0};
            // entry keeps a single g, both halves see it
            lo_g    <= {2{i_rd_entry.g}};
        end else if (i_tlbp) begin
            idx_p   <= ~i_probe_hit;
            idx_val <= i_probe_hit ? i_probe_idx : '0;
        end
    end

    // tlbwi and tlbr both address the entry at Index
    assign o_tlb_we  = i_tlbwi;
    assign o_tlb_idx = idx_val;

    assign o_tlb_wdata = '{
        vpn2: hi_vpn2,
        asid: hi_asid,
        g:    lo_g[0] & lo_g[1],
        pfn0: lo_pfn[0],
        c0:   lo_c[0],
        d0:   lo_d[0],
        v0:   lo_v[0],
        pfn1: lo_pfn[1],
        c1:   lo_c[1],
        d1:   lo_d[1],
        v1:   lo_v[1]
    };

    assign o_index    = '{p: idx_p, zero: '0, index: idx_val};
    assign o_entryhi  = '{vpn2: hi_vpn2, zero: '0, asid: hi_asid};
    assign o_entrylo0 = '{fill: '0, pfn: lo_pfn[0], c: lo_c[0], d: lo_d[0],
                          v: lo_v[0], g: lo_g[0]};
    assign o_entrylo1 = '{fill: '0, pfn: lo_pfn[1], c: lo_c[1], d: lo_d[1],
                          v: lo_v[1], g: lo_g[1]};

endmodule

//--- rtl/addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate
    import tu_pkg::*;
(
    input  word_t                          i_vaddr,
    input  logic                           i_store,
    input  logic                           i_k0_uncached,
    input  logic [7:0]                     i_asid,
    input  tlb_entry_t [TLB_ENTRIES-1:0]   i_entries,

    output word_t                          o_paddr,
    output logic                           o_uncached,
    output logic                           o_refill,
    output logic                           o_invalid,
    output logic                           o_modified
);

    logic        mapped;
    logic        kseg1;
    word_t       paddr_direct;
    logic        uncached_direct;

    logic        tlb_hit;
    logic [19:0] tlb_pfn;
    logic [2:0]  tlb_c;
    logic        tlb_d;
    logic        tlb_v;

    // kseg0/kseg1 are 100/101, everything else goes through the tlb
    assign mapped = (i_vaddr[31:30] != 2'b10);
    assign kseg1  = i_vaddr[29];

    assign paddr_direct    = {3'b000, i_vaddr[28:0]};
    assign uncached_direct = kseg1 | i_k0_uncached;

    tlb_match u_match (
        .i_entries (i_entries),
        .i_vaddr   (i_vaddr),
        .i_asid    (i_asid),
        .o_hit     (tlb_hit),
        .o_idx     (),
        .o_pfn     (tlb_pfn),
        .o_c       (tlb_c),
        .o_d       (tlb_d),
        .o_v       (tlb_v)
    );

    always_comb begin
        if (mapped) begin
            o_paddr    = {tlb_pfn, i_vaddr[11:0]};
            o_uncached = (tlb_c != CACHE_CACHEABLE);
        end else begin
            o_paddr    = paddr_direct;
            o_uncached = uncached_direct;
        end
    end

    // flags are levels only, the pipeline decides when to trap
    assign o_refill   = mapped & ~tlb_hit;
    assign o_invalid  = mapped & tlb_hit & ~tlb_v;
    // store to a clean valid page
    assign o_modified = mapped & tlb_hit & tlb_v & ~tlb_d & i_store;

endmodule

//--- rtl/tlb_match.sv
`timescale 1ns/1ps

module tlb_match
    import tu_pkg::*;
(
    input  tlb_entry_t [TLB_ENTRIES-1:0]   i_entries,
    input  word_t                          i_vaddr,
    input  logic [7:0]                     i_asid,

    output logic                           o_hit,
    output tlb_idx_t                       o_idx,
    output logic [19:0]                    o_pfn,
    output logic [2:0]                     o_c,
    output logic                           o_d,
    output logic                           o_v
);

    logic [TLB_ENTRIES-1:0] hit_mask;
    tlb_idx_t               hit_idx;
    tlb_entry_t             sel_entry;

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_cmp
        assign hit_mask[i] = (i_entries[i].vpn2 == i_vaddr[31:13]) &&
                             ((i_entries[i].asid == i_asid) || i_entries[i].g);
    end

    // lowest matching index wins, 0 when nothing matches
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign sel_entry = i_entries[hit_idx];

    assign o_hit = |hit_mask;
    assign o_idx = hit_idx;

    // bit 12 picks the odd page of the pair
    always_comb begin
        if (i_vaddr[12]) begin
            o_pfn = sel_entry.pfn1;
            o_c   = sel_entry.c1;
            o_d   = sel_entry.d1;
            o_v   = sel_entry.v1;
        end else begin
            o_pfn = sel_entry.pfn0;
            o_c   = sel_entry.c0;
            o_d   = sel_entry.d0;
            o_v   = sel_entry.v0;
        end
    end

endmodule

//--- rtl/tlb_table.sv
`timescale 1ns/1ps

module tlb_table
    import tu_pkg::*;
(
    input  logic                           clk,
    input  logic                           resetn,

    input  logic                           i_we,
    input  tlb_idx_t                       i_waddr,
    input  tlb_entry_t                     i_wdata,

    input  tlb_idx_t                       i_raddr,
    output tlb_entry_t                     o_rdata,

    output tlb_entry_t [TLB_ENTRIES-1:0]   o_entries
);

    tlb_entry_t [TLB_ENTRIES-1:0] entries;

    // one register per entry, written only when its index is addressed
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        always_ff @(posedge clk) begin
            if (!resetn) begin
                entries[i] <= '0;
            end else if (i_we && (i_waddr == tlb_idx_t'(i))) begin
                entries[i] <= i_wdata;
            end
        end
    end

    // tlbr path
    assign o_rdata = entries[i_raddr];

    // every entry goes out so lookups can compare in parallel
    assign o_entries = entries;

endmodule

//--- rtl/tu_pkg.sv
package tu_pkg;

    localparam int TLB_ENTRIES = 16;

    typedef logic [3:0]  tlb_idx_t;
    typedef logic [31:0] word_t;

    // joint entry, one vpn2 maps an even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zero;
        logic [7:0]  asid;
    } cp0_entryhi_t;

    typedef struct packed {
        logic [5:0]  fill;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } cp0_entrylo_t;

    typedef struct packed {
        logic        p;
        logic [26:0] zero;
        tlb_idx_t    index;
    } cp0_index_t;

    // mtc0 data, read through whichever view matches the selected register
    typedef union packed {
        word_t        raw;
        cp0_entryhi_t entryhi;
        cp0_entrylo_t entrylo;
        cp0_index_t   index;
    } cp0_word_u;

    localparam logic [1:0] CP0_SEL_INDEX    = 2'd0;
    localparam logic [1:0] CP0_SEL_ENTRYHI  = 2'd1;
    localparam logic [1:0] CP0_SEL_ENTRYLO0 = 2'd2;
    localparam logic [1:0] CP0_SEL_ENTRYLO1 = 2'd3;

    localparam logic [2:0] CACHE_CACHEABLE = 3'd3;

endpackage
